/* src/matadd_macros.svh */
// Sizes are fixed for 8x8 byte matrices; RAM addresses wrap at 2^AWIDTH bytes
`ifndef MATADD_MACROS_SVH
`define MATADD_MACROS_SVH

// Data path sizes
`define DWIDTH        8
`define MAT_SIZE      8
`define AWIDTH        10
`define STRIDE_WIDTH  16

// APB bus widths
`define REG_DWIDTH    32
`define REG_AWIDTH    8

// Register map
`define REG_CTRL_ADDR      8'h00
`define REG_A_ADDR         8'h0E
`define REG_B_ADDR         8'h12
`define REG_C_ADDR         8'h16
`define REG_MASK_ADDR      8'h20
`define REG_A_STRIDE_ADDR  8'h28
`define REG_B_STRIDE_ADDR  8'h32
`define REG_C_STRIDE_ADDR  8'h36

// Control register bits
`define START_BIT  0
`define DONE_BIT   31

// Reset values of the configuration registers
`define STRIDE_RST 16'd8
`define MASK_RST   8'hFF

// External bank codes
`define BANK_A 8'd0
`define BANK_B 8'd1
`define BANK_C 8'd2

`endif

/* src/matadd_pkg.sv */
// Types assume the widths in matadd_macros.svh; a row is MAT_SIZE packed elements, lane 0 at LSB
`include "matadd_macros.svh"

package matadd_pkg;

  // Data path vectors
  typedef logic [`DWIDTH-1:0]              elem_t;
  typedef logic [`MAT_SIZE*`DWIDTH-1:0]    row_t;
  typedef logic [`AWIDTH-1:0]              addr_t;
  typedef logic [`STRIDE_WIDTH-1:0]        stride_t;
  typedef logic [`MAT_SIZE-1:0]            mask_t;

  // Register bus vectors
  typedef logic [`REG_DWIDTH-1:0]          reg_data_t;
  typedef logic [`REG_AWIDTH-1:0]          reg_addr_t;

  // Run control
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_t;

  // APB transfer decode
  typedef enum logic [1:0] {
    SETUP_WAIT,
    WRITE_ACCESS,
    READ_ACCESS
  } apb_state_t;

endpackage

/* src/ram_port_if.sv */
// One RAM port; rdata follows addr by one clock and we is a per-byte write mask
`timescale 1ns/1ps

interface ram_port_if;
  import matadd_pkg::*;

  addr_t addr;
  row_t  wdata;
  mask_t we;
  row_t  rdata;

  // Sequencer side
  modport requester (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  // RAM side
  modport memory (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

/* src/byte_ram.sv */
// Same-byte writes from both ports in one cycle are unsupported; row accesses wrap at the top
`timescale 1ns/1ps
`include "matadd_macros.svh"

module byte_ram (
  input  logic              clk,
  ram_port_if.memory        mem_port,
  input  matadd_pkg::addr_t ext_addr,
  input  matadd_pkg::row_t  ext_wdata,
  input  matadd_pkg::mask_t ext_we,
  output matadd_pkg::row_t  ext_rdata
);
  import matadd_pkg::*;

  elem_t mem [0:(1<<`AWIDTH)-1];

  //////////////////////////////
  // Both ports, one clock
  //////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MAT_SIZE; i++) begin
      // Internal port, masked per byte
      if (mem_port.we[i]) begin
        mem[addr_t'(mem_port.addr + i)] <= mem_port.wdata[i*`DWIDTH +: `DWIDTH];
      end
      // External port writes at its own address
      if (ext_we[i]) begin
        mem[addr_t'(ext_addr + i)] <= ext_wdata[i*`DWIDTH +: `DWIDTH];
      end
    end
  end

  // Registered row reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MAT_SIZE; i++) begin
      mem_port.rdata[i*`DWIDTH +: `DWIDTH] <= mem[addr_t'(mem_port.addr + i)];
      ext_rdata[i*`DWIDTH +: `DWIDTH]      <= mem[addr_t'(ext_addr + i)];
    end
  end

endmodule

/* src/apb_regs.sv */
// Master must hold the access phase until PREADY; unmapped addresses share one dummy register
`timescale 1ns/1ps
`include "matadd_macros.svh"

module apb_regs (
  input  logic                   clk,
  input  logic                   PRESETn,
  input  matadd_pkg::reg_addr_t  PADDR,
  input  logic                   PWRITE,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  matadd_pkg::reg_data_t  PWDATA,
  output matadd_pkg::reg_data_t  PRDATA,
  output logic                   PREADY,
  input  logic                   busy,
  input  logic                   done,
  output matadd_pkg::addr_t      base_a,
  output matadd_pkg::addr_t      base_b,
  output matadd_pkg::addr_t      base_c,
  output matadd_pkg::stride_t    stride_a,
  output matadd_pkg::stride_t    stride_b,
  output matadd_pkg::stride_t    stride_c,
  output matadd_pkg::mask_t      row_mask,
  output matadd_pkg::mask_t      lane_mask,
  output logic                   start_pulse,
  output logic                   clear_pulse
);
  import matadd_pkg::*;

  apb_state_t apb_state;
  mask_t      mask_rsvd;
  reg_data_t  dummy_reg;
  reg_data_t  status_word;

  // Control read view
  always_comb begin
    status_word = '0;
    status_word[`DONE_BIT]  = done;
    status_word[`START_BIT] = busy;
  end

  //////////////////////////////
  // Transfer FSM and registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      apb_state   <= SETUP_WAIT;
      PRDATA      <= '0;
      PREADY      <= 1'b0;
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
      base_a      <= '0;
      base_b      <= '0;
      base_c      <= '0;
      stride_a    <= `STRIDE_RST;
      stride_b    <= `STRIDE_RST;
      stride_c    <= `STRIDE_RST;
      row_mask    <= `MASK_RST;
      mask_rsvd   <= `MASK_RST;
      lane_mask   <= `MASK_RST;
      dummy_reg   <= '0;
    end else begin
      // Pulses last one cycle
      start_pulse <= 1'b0;
      clear_pulse <= 1'b0;
      case (apb_state)
        SETUP_WAIT: begin
          PREADY <= 1'b0;
          PRDATA <= '0;
          // Only a fresh setup phase opens a transfer
          if (PSEL && !PENABLE) begin
            if (PWRITE) begin
              apb_state <= WRITE_ACCESS;
            end else begin
              apb_state <= READ_ACCESS;
            end
          end
        end
        WRITE_ACCESS: begin
          if (PSEL && PENABLE) begin
            case (PADDR)
              `REG_CTRL_ADDR: begin
                start_pulse <= PWDATA[`START_BIT];
                clear_pulse <= PWDATA[`DONE_BIT];
              end
              `REG_A_ADDR:        base_a   <= PWDATA[`AWIDTH-1:0];
              `REG_B_ADDR:        base_b   <= PWDATA[`AWIDTH-1:0];
              `REG_C_ADDR:        base_c   <= PWDATA[`AWIDTH-1:0];
              `REG_MASK_ADDR: begin
                row_mask  <= PWDATA[7:0];
                mask_rsvd <= PWDATA[15:8];
                lane_mask <= PWDATA[23:16];
              end
              `REG_A_STRIDE_ADDR: stride_a <= PWDATA[`STRIDE_WIDTH-1:0];
              `REG_B_STRIDE_ADDR: stride_b <= PWDATA[`STRIDE_WIDTH-1:0];
              `REG_C_STRIDE_ADDR: stride_c <= PWDATA[`STRIDE_WIDTH-1:0];
              default:            dummy_reg <= PWDATA;
            endcase
            PREADY <= 1'b1;
          end
          apb_state <= SETUP_WAIT;
        end
        READ_ACCESS: begin
          if (PSEL && PENABLE) begin
            case (PADDR)
              `REG_CTRL_ADDR:     PRDATA <= status_word;
              `REG_A_ADDR:        PRDATA <= reg_data_t'(base_a);
              `REG_B_ADDR:        PRDATA <= reg_data_t'(base_b);
              `REG_C_ADDR:        PRDATA <= reg_data_t'(base_c);
              `REG_MASK_ADDR:     PRDATA <= {8'h00, lane_mask, mask_rsvd, row_mask};
              `REG_A_STRIDE_ADDR: PRDATA <= reg_data_t'(stride_a);
              `REG_B_STRIDE_ADDR: PRDATA <= reg_data_t'(stride_b);
              `REG_C_STRIDE_ADDR: PRDATA <= reg_data_t'(stride_c);
              default:            PRDATA <= dummy_reg;
            endcase
            PREADY <= 1'b1;
          end
          apb_state <= SETUP_WAIT;
        end
        default: apb_state <= SETUP_WAIT;
      endcase
    end
  end

endmodule

/* src/row_sequencer.sv */
// Run length is fixed at MAT_SIZE rows; RAM contents must not change externally during a run
`timescale 1ns/1ps
`include "matadd_macros.svh"

module row_sequencer (
  input  logic                 clk,
  input  logic                 PRESETn,
  input  matadd_pkg::addr_t    base_a,
  input  matadd_pkg::addr_t    base_b,
  input  matadd_pkg::addr_t    base_c,
  input  matadd_pkg::stride_t  stride_a,
  input  matadd_pkg::stride_t  stride_b,
  input  matadd_pkg::stride_t  stride_c,
  input  matadd_pkg::mask_t    row_mask,
  input  matadd_pkg::mask_t    lane_mask,
  input  logic                 start_pulse,
  input  logic                 clear_pulse,
  output logic                 busy,
  output logic                 done,
  ram_port_if.requester        port_a,
  ram_port_if.requester        port_b,
  ram_port_if.requester        port_c
);
  import matadd_pkg::*;

  localparam int ROW_W = $clog2(`MAT_SIZE);

  ctrl_state_t      state;
  logic [ROW_W:0]   rd_cnt;
  logic             rd_valid;
  logic             wr_valid;
  logic [ROW_W-1:0] wr_row;
  row_t             sum_row;

  //////////////////////////////
  // Control FSM
  //////////////////////////////
  // One extra RUN cycle after the last read lets the row 7 write drain
  assign rd_valid = (state == RUN) && (rd_cnt < `MAT_SIZE);

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state    <= IDLE;
      rd_cnt   <= '0;
      wr_valid <= 1'b0;
      wr_row   <= '0;
    end else begin
      // Write stage trails the read by one cycle
      wr_valid <= rd_valid;
      wr_row   <= rd_cnt[ROW_W-1:0];
      case (state)
        IDLE: begin
          if (start_pulse) begin
            state  <= RUN;
            rd_cnt <= '0;
          end
        end
        RUN: begin
          if (rd_valid) begin
            rd_cnt <= rd_cnt + 1'b1;
          end
          if (wr_valid && (wr_row == (`MAT_SIZE - 1))) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (clear_pulse) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy = (state == RUN);
  assign done = (state == DONE);

  //////////////////////////////
  // Read address generation
  //////////////////////////////
  // Row address is base + row * stride, modulo the RAM size
  assign port_a.addr  = addr_t'(base_a + rd_cnt * stride_a);
  assign port_b.addr  = addr_t'(base_b + rd_cnt * stride_b);
  assign port_a.wdata = '0;
  assign port_b.wdata = '0;
  assign port_a.we    = '0;
  assign port_b.we    = '0;

  //////////////////////////////
  // Adder and C write
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < `MAT_SIZE; i++) begin
      // Byte sums wrap mod 256
      sum_row[i*`DWIDTH +: `DWIDTH] = elem_t'(port_a.rdata[i*`DWIDTH +: `DWIDTH]
                                             + port_b.rdata[i*`DWIDTH +: `DWIDTH]);
    end
  end

  assign port_c.addr  = addr_t'(base_c + wr_row * stride_c);
  assign port_c.wdata = sum_row;
  // Masked rows write nothing
  assign port_c.we    = (wr_valid && row_mask[wr_row]) ? lane_mask : '0;

endmodule

/* src/matrix_add_top.sv */
// External writes during a run are unsupported; ext_rdata follows the bank select by one clock
`timescale 1ns/1ps
`include "matadd_macros.svh"

module matrix_add_top (
  input  logic                   clk,
  input  logic                   PRESETn,
  input  matadd_pkg::reg_addr_t  PADDR,
  input  logic                   PWRITE,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  matadd_pkg::reg_data_t  PWDATA,
  output matadd_pkg::reg_data_t  PRDATA,
  output logic                   PREADY,
  input  logic [7:0]             bank_sel,
  input  matadd_pkg::addr_t      ext_addr,
  input  matadd_pkg::row_t       ext_wdata,
  input  matadd_pkg::mask_t      ext_we,
  output matadd_pkg::row_t       ext_rdata
);
  import matadd_pkg::*;

  addr_t      base_a;
  addr_t      base_b;
  addr_t      base_c;
  stride_t    stride_a;
  stride_t    stride_b;
  stride_t    stride_c;
  mask_t      row_mask;
  mask_t      lane_mask;
  logic       start_pulse;
  logic       clear_pulse;
  logic       busy;
  logic       done;
  mask_t      ext_we_a;
  mask_t      ext_we_b;
  mask_t      ext_we_c;
  row_t       ext_rdata_a;
  row_t       ext_rdata_b;
  row_t       ext_rdata_c;
  logic [7:0] bank_sel_q;

  ram_port_if port_a ();
  ram_port_if port_b ();
  ram_port_if port_c ();

  //////////////////////////////
  // Register block and sequencer
  //////////////////////////////
  apb_regs u_apb_regs (
    .clk, .PRESETn, .PADDR, .PWRITE, .PSEL, .PENABLE, .PWDATA, .PRDATA, .PREADY,
    .busy, .done, .base_a, .base_b, .base_c, .stride_a, .stride_b, .stride_c,
    .row_mask, .lane_mask, .start_pulse, .clear_pulse
  );

  row_sequencer u_row_sequencer (
    .clk, .PRESETn, .base_a, .base_b, .base_c, .stride_a, .stride_b, .stride_c,
    .row_mask, .lane_mask, .start_pulse, .clear_pulse, .busy, .done,
    .port_a(port_a), .port_b(port_b), .port_c(port_c)
  );

  //////////////////////////////
  // Matrix RAMs and external port
  //////////////////////////////
  // Only the selected bank sees the write mask
  assign ext_we_a = (bank_sel == `BANK_A) ? ext_we : '0;
  assign ext_we_b = (bank_sel == `BANK_B) ? ext_we : '0;
  assign ext_we_c = (bank_sel == `BANK_C) ? ext_we : '0;

  byte_ram ram_a (.clk, .mem_port(port_a), .ext_addr, .ext_wdata,
                  .ext_we(ext_we_a), .ext_rdata(ext_rdata_a));
  byte_ram ram_b (.clk, .mem_port(port_b), .ext_addr, .ext_wdata,
                  .ext_we(ext_we_b), .ext_rdata(ext_rdata_b));
  byte_ram ram_c (.clk, .mem_port(port_c), .ext_addr, .ext_wdata,
                  .ext_we(ext_we_c), .ext_rdata(ext_rdata_c));

  // Bank select aligned with the RAM read latency
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      bank_sel_q <= '0;
    end else begin
      bank_sel_q <= bank_sel;
    end
  end

  always_comb begin
    case (bank_sel_q)
      `BANK_A: ext_rdata = ext_rdata_a;
      `BANK_B: ext_rdata = ext_rdata_b;
      `BANK_C: ext_rdata = ext_rdata_c;
      default: ext_rdata = '0;
    endcase
  end

endmodule

/* tests/matrix_add_asserts.sv */
// Bound into matrix_add_top; all checks except the reset one are off while PRESETn is low
`timescale 1ns/1ps

module matrix_add_asserts (
  input logic              clk,
  input logic              PRESETn,
  input logic              PREADY,
  input logic              busy,
  input logic              done,
  input matadd_pkg::mask_t lane_mask,
  input matadd_pkg::mask_t c_we
);
  import matadd_pkg::*;

  // Count of failed assertions
  int    err_count = 0;
  mask_t stray_we;

  // C lanes enabled outside the lane mask
  assign stray_we = c_we & ~lane_mask;

  //////////////////////////////
  // APB handshake
  //////////////////////////////
  a_pready_one_cycle: assert property (@(posedge clk) disable iff (!PRESETn)
    PREADY |=> !PREADY)
    else begin
      err_count++;
      $error("PREADY stayed high for two cycles");
    end

  a_pready_after_reset: assert property (@(posedge clk) !PRESETn |=> !PREADY)
    else begin
      err_count++;
      $error("PREADY high in the cycle after reset");
    end

  //////////////////////////////
  // Sequencer
  //////////////////////////////
  a_busy_done_excl: assert property (@(posedge clk) disable iff (!PRESETn)
    !(busy && done))
    else begin
      err_count++;
      $error("busy and done high together");
    end

  a_c_we_in_lanes: assert property (@(posedge clk) disable iff (!PRESETn)
    stray_we == '0)
    else begin
      err_count++;
      $error("C write enable outside lane_mask");
    end

endmodule

bind matrix_add_top matrix_add_asserts u_asserts (
  .clk,
  .PRESETn,
  .PREADY,
  .busy,
  .done,
  .lane_mask,
  .c_we(port_c.we)
);

/* tests/tb_matrix_add.sv */
// Byte model tracks only RAM bytes written through this bench; external writes use full masks
`timescale 1ns/1ps
`include "matadd_macros.svh"

module tb_matrix_add;
  import matadd_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int APB_CYCLES = 6;
  localparam int EXT_CYCLES = 3;
  localparam int POLL_LIMIT = 40;
  localparam int WATCHDOG_CYCLES =
    2 * (5 * 20 * APB_CYCLES + 64 * EXT_CYCLES + 3 * POLL_LIMIT * APB_CYCLES);
  localparam int MEM_BYTES = 1 << `AWIDTH;

  logic       clk;
  logic       PRESETn;
  reg_addr_t  PADDR;
  logic       PWRITE;
  logic       PSEL;
  logic       PENABLE;
  reg_data_t  PWDATA;
  reg_data_t  PRDATA;
  logic       PREADY;
  logic [7:0] bank_sel;
  addr_t      ext_addr;
  row_t       ext_wdata;
  mask_t      ext_we;
  row_t       ext_rdata;

  // Expected RAM contents per bank, and the configuration last written
  elem_t      model [0:2][0:MEM_BYTES-1];
  addr_t      cfg_base [0:2];
  stride_t    cfg_stride [0:2];
  mask_t      cfg_row_mask;
  mask_t      cfg_lane_mask;
  int         seed;

  matrix_add_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Failure handling
  //////////////////////////////
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got));
    end
  endtask

  always @(negedge clk) begin
    if (uut.u_asserts.err_count != 0) begin
      abort_run("A bound assertion on the DUT failed");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired before the tests completed");
  end

  //////////////////////////////
  // APB master
  //////////////////////////////
  task automatic apb_transfer(input reg_addr_t addr, input logic write,
                              input reg_data_t wdata, output reg_data_t rdata);
    int waits;
    waits = 0;
    @(posedge clk);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= write;
    PADDR   <= addr;
    PWDATA  <= wdata;
    @(posedge clk);
    PENABLE <= 1'b1;
    do begin
      @(negedge clk);
      waits++;
      if (waits > 8) begin
        abort_run("APB transfer saw no PREADY within 8 cycles");
      end
    end while (!PREADY);
    rdata = PRDATA;
    @(posedge clk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic apb_write(input reg_addr_t addr, input reg_data_t wdata);
    reg_data_t unused;
    apb_transfer(addr, 1'b1, wdata, unused);
  endtask

  task automatic apb_read_check(input reg_addr_t addr, input reg_data_t exp);
    reg_data_t rdata;
    apb_transfer(addr, 1'b0, '0, rdata);
    check_value($sformatf("PRDATA @%h", addr), rdata, exp);
  endtask

  task automatic write_readback(input reg_addr_t addr, input reg_data_t wdata,
                                input reg_data_t exp);
    apb_write(addr, wdata);
    apb_read_check(addr, exp);
  endtask

  //////////////////////////////
  // External RAM port
  //////////////////////////////
  task automatic ext_write(input logic [7:0] bank, input addr_t addr, input row_t data);
    @(posedge clk);
    bank_sel  <= bank;
    ext_addr  <= addr;
    ext_wdata <= data;
    ext_we    <= '1;
    @(posedge clk);
    ext_we    <= '0;
    for (int i = 0; i < `MAT_SIZE; i++) begin
      model[bank][addr_t'(addr + i)] = data[i*`DWIDTH +: `DWIDTH];
    end
  endtask

  task automatic ext_read_check(input logic [7:0] bank, input addr_t addr, input row_t exp);
    @(posedge clk);
    bank_sel <= bank;
    ext_addr <= addr;
    ext_we   <= '0;
    @(posedge clk);
    @(negedge clk);
    check_value($sformatf("ext_rdata bank %0d @%h", bank, addr), ext_rdata, exp);
  endtask

  function automatic row_t model_row(input int bank, input addr_t addr);
    row_t row;
    for (int i = 0; i < `MAT_SIZE; i++) begin
      row[i*`DWIDTH +: `DWIDTH] = model[bank][addr_t'(addr + i)];
    end
    return row;
  endfunction

  // Pattern byte mixes the upper address bits into the low byte
  function automatic row_t pattern_row(input addr_t addr);
    row_t  row;
    addr_t a;
    for (int i = 0; i < `MAT_SIZE; i++) begin
      a = addr_t'(addr + i);
      row[i*`DWIDTH +: `DWIDTH] = a[7:0] ^ {4{a[9:8]}};
    end
    return row;
  endfunction

  task automatic load_random_rows(input logic [7:0] bank, input addr_t base, input stride_t st);
    for (int r = 0; r < `MAT_SIZE; r++) begin
      ext_write(bank, addr_t'(base + r * st), {$random(seed), $random(seed)});
    end
  endtask

  task automatic check_c_rows();
    addr_t c_row;
    for (int r = 0; r < `MAT_SIZE; r++) begin
      c_row = addr_t'(cfg_base[2] + r * cfg_stride[2]);
      ext_read_check(`BANK_C, c_row, model_row(2, c_row));
    end
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////
  task automatic configure(input addr_t ba, input addr_t bb, input addr_t bc,
                           input stride_t sa, input stride_t sb, input stride_t sc,
                           input mask_t rows, input mask_t lanes);
    apb_write(`REG_A_ADDR, ba);
    apb_write(`REG_B_ADDR, bb);
    apb_write(`REG_C_ADDR, bc);
    apb_write(`REG_A_STRIDE_ADDR, sa);
    apb_write(`REG_B_STRIDE_ADDR, sb);
    apb_write(`REG_C_STRIDE_ADDR, sc);
    apb_write(`REG_MASK_ADDR, {8'h00, lanes, 8'h00, rows});
    cfg_base     = '{ba, bb, bc};
    cfg_stride   = '{sa, sb, sc};
    cfg_row_mask  = rows;
    cfg_lane_mask = lanes;
  endtask

  // C = A + B mod 256 on enabled rows and lanes
  task automatic add_model_sums();
    addr_t a_row;
    addr_t b_row;
    addr_t c_row;
    for (int r = 0; r < `MAT_SIZE; r++) begin
      a_row = addr_t'(cfg_base[0] + r * cfg_stride[0]);
      b_row = addr_t'(cfg_base[1] + r * cfg_stride[1]);
      c_row = addr_t'(cfg_base[2] + r * cfg_stride[2]);
      for (int l = 0; l < `MAT_SIZE; l++) begin
        if (cfg_row_mask[r] && cfg_lane_mask[l]) begin
          model[2][addr_t'(c_row + l)] = model[0][addr_t'(a_row + l)]
                                       + model[1][addr_t'(b_row + l)];
        end
      end
    end
  endtask

  task automatic run_matrix_add();
    reg_data_t ctrl;
    bit        seen_busy;
    int        polls;
    seen_busy = 1'b0;
    polls     = 0;
    apb_write(`REG_CTRL_ADDR, 32'h0000_0001);
    do begin
      apb_transfer(`REG_CTRL_ADDR, 1'b0, '0, ctrl);
      if (ctrl[`START_BIT]) begin
        seen_busy = 1'b1;
      end
      polls++;
      if (polls > POLL_LIMIT) begin
        abort_run("done was not seen within the polling limit");
      end
    end while (!ctrl[`DONE_BIT]);
    assert (seen_busy) else abort_run("busy was never seen before done");
    check_value("PRDATA ctrl", ctrl, 32'h8000_0000);
    add_model_sums();
  endtask

  task automatic clear_done();
    apb_write(`REG_CTRL_ADDR, 32'h8000_0000);
    apb_read_check(`REG_CTRL_ADDR, 32'h0000_0000);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    clk       = 1'b0;
    PRESETn   = 1'b0;
    PADDR     = '0;
    PWRITE    = 1'b0;
    PSEL      = 1'b0;
    PENABLE   = 1'b0;
    PWDATA    = '0;
    bank_sel  = '0;
    ext_addr  = '0;
    ext_wdata = '0;
    ext_we    = '0;
    seed      = 32'hb372;
    repeat (2) @(posedge clk);
    PRESETn <= 1'b1;

    // Reset values, then writes truncated to field widths
    apb_read_check(`REG_CTRL_ADDR, 32'h0000_0000);
    apb_read_check(`REG_A_ADDR, 32'h0000_0000);
    apb_read_check(`REG_B_ADDR, 32'h0000_0000);
    apb_read_check(`REG_C_ADDR, 32'h0000_0000);
    apb_read_check(`REG_A_STRIDE_ADDR, 32'h0000_0008);
    apb_read_check(`REG_B_STRIDE_ADDR, 32'h0000_0008);
    apb_read_check(`REG_C_STRIDE_ADDR, 32'h0000_0008);
    apb_read_check(`REG_MASK_ADDR, 32'h00FF_FFFF);
    write_readback(`REG_A_ADDR, 32'hFFFF_F3A5, 32'h0000_03A5);
    write_readback(`REG_B_ADDR, 32'h0000_0C5A, 32'h0000_005A);
    write_readback(`REG_C_ADDR, 32'h8000_02F1, 32'h0000_02F1);
    write_readback(`REG_A_STRIDE_ADDR, 32'hABCD_1234, 32'h0000_1234);
    write_readback(`REG_B_STRIDE_ADDR, 32'h0001_0010, 32'h0000_0010);
    write_readback(`REG_C_STRIDE_ADDR, 32'hFFFF_FFFF, 32'h0000_FFFF);
    write_readback(`REG_MASK_ADDR, 32'h5AC3_9669, 32'h00C3_9669);

    // Unmapped addresses share the dummy word
    apb_write(8'h44, 32'hDEAD_BEEF);
    apb_read_check(8'hF0, 32'hDEAD_BEEF);

    // Full run at base 0, stride 8
    load_random_rows(`BANK_A, '0, 16'd8);
    load_random_rows(`BANK_B, '0, 16'd8);
    configure('0, '0, '0, 16'd8, 16'd8, 16'd8, 8'hFF, 8'hFF);
    run_matrix_add();
    check_c_rows();
    ext_read_check(8'd3, '0, '0);
    clear_done();

    // Row and lane masks over a preloaded C
    for (int r = 0; r < `MAT_SIZE; r++) begin
      ext_write(`BANK_C, addr_t'(r * 8), pattern_row(addr_t'(r * 8)));
    end
    configure('0, '0, '0, 16'd8, 16'd8, 16'd8, 8'hA5, 8'h3C);
    run_matrix_add();
    check_c_rows();
    clear_done();

    // Odd bases and strides, C wraps past the top of the RAM
    load_random_rows(`BANK_A, 10'h100, 16'd24);
    load_random_rows(`BANK_B, 10'h203, 16'd16);
    configure(10'h100, 10'h203, 10'h3F0, 16'd24, 16'd16, 16'd40, 8'hFF, 8'hFF);
    run_matrix_add();
    check_c_rows();
    clear_done();
    // New A rows so the second run has to rewrite C
    load_random_rows(`BANK_A, 10'h100, 16'd24);
    run_matrix_add();
    check_c_rows();
    clear_done();

    if (uut.u_asserts.err_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("A bound assertion on the DUT failed");
    end
  end

endmodule

/* compile.f */
+incdir+src
src/matadd_pkg.sv
src/ram_port_if.sv
src/byte_ram.sv
src/apb_regs.sv
src/row_sequencer.sv
src/matrix_add_top.sv
tests/matrix_add_asserts.sv
tests/tb_matrix_add.sv

/* Bender.yml */
package:
  name: matrix_add

sources:
  - include_dirs:
      - src
    files:
      - src/matadd_pkg.sv
      - src/ram_port_if.sv
      - src/byte_ram.sv
      - src/apb_regs.sv
      - src/row_sequencer.sv
      - src/matrix_add_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/matrix_add_asserts.sv
      - tests/tb_matrix_add.sv
